//--- build.f
+incdir+src
src/tlb_pkg.sv
src/tlb_lookup.sv
src/tlb.sv
src/tlb_op_unit.sv
src/mmu_top.sv
tb/tb_clock.sv
tb/mmu_props.sv
tb/mmu_tb.sv

//--- Makefile
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator, run it and check sim.log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
		--top-module mmu_tb -f build.f --Mdir obj_dir -o mmu_sim
	./obj_dir/mmu_sim | tee sim.log
	@grep -q "Simulation PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

//--- tb/mmu_tb.sv
`include "tlb_defs.svh"

module mmu_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int N_CMDS      = 300;
    localparam int N_XLATES    = 400;
    localparam int CYCLE_LIMIT = 4 * (N_CMDS * 6 + N_XLATES * 2);

    logic                clk;
    logic                rst;
    logic [7:0]          asid;
    tlb_pkg::vaddr_t     inst_vaddr;
    tlb_pkg::paddr_t     inst_paddr;
    logic                inst_miss;
    logic                inst_valid;
    logic                inst_uncached;
    tlb_pkg::vaddr_t     data_vaddr;
    tlb_pkg::paddr_t     data_paddr;
    logic                data_miss;
    logic                data_valid;
    logic                data_dirty;
    logic                data_uncached;
    logic                cmd_valid;
    logic                cmd_ready;
    tlb_pkg::tlb_op_e    cmd_op;
    tlb_pkg::tlb_index_t cmd_index;
    tlb_pkg::tlb_entry_t cmd_entry;
    logic                rsp_valid;
    logic                rsp_ready;
    tlb_pkg::tlb_index_t rsp_index;
    tlb_pkg::tlb_entry_t rsp_entry;
    logic                rsp_miss;

    tlb_pkg::tlb_entry_t model [0:`TLB_ENTRIES-1];
    tlb_pkg::tlb_index_t last_index;
    logic [15:0]         lfsr;
    logic                stall_mode;
    int                  edge_cnt;  // edges since reset mirror the random counter
    int                  cycles;
    int                  acc_seen;
    int                  rsp_seen;

    tb_clock i_clock (.clk_o(clk));

    mmu_top i_dut (
        .clk (clk), .rst (rst), .asid_i (asid),
        .inst_vaddr_i (inst_vaddr), .inst_paddr_o (inst_paddr), .inst_miss_o (inst_miss),
        .inst_valid_o (inst_valid), .inst_uncached_o (inst_uncached),
        .data_vaddr_i (data_vaddr), .data_paddr_o (data_paddr), .data_miss_o (data_miss),
        .data_valid_o (data_valid), .data_dirty_o (data_dirty),
        .data_uncached_o (data_uncached),
        .cmd_valid_i (cmd_valid), .cmd_ready_o (cmd_ready), .cmd_op_i (cmd_op),
        .cmd_index_i (cmd_index), .cmd_entry_i (cmd_entry),
        .rsp_valid_o (rsp_valid), .rsp_ready_i (rsp_ready), .rsp_index_o (rsp_index),
        .rsp_entry_o (rsp_entry), .rsp_miss_o (rsp_miss)
    );

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_paddr(input string name, input tlb_pkg::paddr_t got,
                               input tlb_pkg::paddr_t exp);
        if (got !== exp) begin
            abort_run($sformatf("Fail at %0t ns: %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_entry(input string name, input tlb_pkg::tlb_entry_t got,
                               input tlb_pkg::tlb_entry_t exp);
        if (got !== exp) begin
            abort_run($sformatf("Fail at %0t ns: %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_index(input string name, input tlb_pkg::tlb_index_t got,
                               input tlb_pkg::tlb_index_t exp);
        if (got !== exp) begin
            abort_run($sformatf("Fail at %0t ns: %s got %0d expected %0d", $time, name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("Fail at %0t ns: %s got %b expected %b", $time, name, got, exp));
        end
    endtask

    // fibonacci lfsr with taps x^16 + x^14 + x^13 + x^11 + 1 steps once per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            r    = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic logic [18:0] pool_vpn2(input logic [2:0] k);
        return {16'h2a5c, k};
    endfunction

    function automatic logic [7:0] pool_asid(input logic k);
        return k ? 8'h3a : 8'h05;
    endfunction

    function automatic logic [`TLB_PAGE_W-1:0] rand_page();
        logic [19:0] pfn;
        logic [2:0]  c;
        logic [1:0]  dv;
        pfn = 20'(rand_bits(20));
        c   = 3'(rand_bits(3));
        dv  = 2'(rand_bits(2));
        return {pfn, c, dv};
    endfunction

    // entries draw from four VPN2 values and addresses from eight so duplicates and misses occur
    function automatic tlb_pkg::tlb_entry_t rand_entry();
        logic [7:0]  a;
        logic [18:0] vpn2;
        logic        g;
        logic [24:0] even;
        logic [24:0] odd;
        a    = pool_asid(rand_bits(1) != 0);
        vpn2 = pool_vpn2(3'(rand_bits(2)));
        g    = (rand_bits(2) == 0);
        even = rand_page();
        odd  = rand_page();
        return {a, 7'b0, vpn2, g, even, odd, 1'b0};
    endfunction

    function automatic tlb_pkg::vaddr_t rand_vaddr();
        return {pool_vpn2(3'(rand_bits(3))), 13'(rand_bits(13))};
    endfunction

    function automatic logic find_match(input tlb_pkg::vaddr_t va, input logic [7:0] as,
                                        output tlb_pkg::tlb_index_t idx);
        logic found;
        found = 1'b0;
        idx   = '0;
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            if (!found && model[i][`TLB_VPN2_HI:`TLB_VPN2_LO] == va[31:13] &&
                (model[i][`TLB_G_BIT] || model[i][`TLB_ASID_HI:`TLB_ASID_LO] == as)) begin
                found = 1'b1;
                idx   = tlb_pkg::tlb_index_t'(i);
            end
        end
        return found;
    endfunction

    task automatic check_port(input string port, input tlb_pkg::vaddr_t va,
                              input tlb_pkg::paddr_t pa, input logic miss, input logic valid,
                              input logic dirty, input logic unc, input logic has_dirty);
        tlb_pkg::tlb_index_t idx;
        logic                hit;
        logic [24:0]         page;
        hit  = find_match(va, asid, idx);
        page = va[12] ? model[idx][`TLB_ODD_HI:`TLB_ODD_LO]
                      : model[idx][`TLB_EVEN_HI:`TLB_EVEN_LO];
        if (!hit) begin
            page = '0;  // a miss reports all flags low
        end
        check_flag({port, "_miss_o"}, miss, !hit);
        check_paddr({port, "_paddr_o"}, pa,
                    hit ? {page[`TLB_PFN_HI:`TLB_PFN_LO], va[11:0]} : 32'h0);
        check_flag({port, "_valid_o"}, valid, page[`TLB_V_BIT]);
        if (has_dirty) begin
            check_flag({port, "_dirty_o"}, dirty, page[`TLB_D_BIT]);
        end
        check_flag({port, "_uncached_o"}, unc,
                   page[`TLB_C_HI:`TLB_C_LO] == 3'(`TLB_C_UNCACHED));
    endtask

    task automatic translate_random();
        @(posedge clk);
        #2;
        inst_vaddr = rand_vaddr();
        data_vaddr = rand_vaddr();
        asid       = pool_asid(rand_bits(1) != 0);
        @(negedge clk);
        check_port("inst", inst_vaddr, inst_paddr, inst_miss, inst_valid, 1'b0,
                   inst_uncached, 1'b0);
        check_port("data", data_vaddr, data_paddr, data_miss, data_valid, data_dirty,
                   data_uncached, 1'b1);
    endtask

    task automatic issue(input tlb_pkg::tlb_op_e op, input tlb_pkg::tlb_index_t idx,
                         input tlb_pkg::tlb_entry_t entry);
        tlb_pkg::tlb_index_t exp_index;
        tlb_pkg::tlb_entry_t exp_entry;
        logic                exp_miss;
        tlb_pkg::tlb_index_t hit_index;
        logic                done;
        @(posedge clk);
        #2;
        cmd_valid = 1'b1;
        cmd_op    = op;
        cmd_index = idx;
        cmd_entry = entry;
        rsp_ready = stall_mode ? (rand_bits(2) == 0) : 1'b1;
        @(negedge clk);
        while (!cmd_ready) begin
            @(negedge clk);
        end
        // the command is accepted at the coming edge and sees the model state as it is now
        exp_entry = '0;
        exp_miss  = 1'b0;
        exp_index = idx;
        case (op)
            tlb_pkg::TLB_OP_READ:         exp_entry = model[idx];
            tlb_pkg::TLB_OP_WRITE_RANDOM: begin
                exp_index = tlb_pkg::tlb_index_t'(`TLB_ENTRIES - 1 - edge_cnt);
            end
            tlb_pkg::TLB_OP_PROBE: begin
                exp_miss  = !find_match({entry[`TLB_VPN2_HI:`TLB_VPN2_LO], 13'b0}, asid,
                                        hit_index);
                exp_index = hit_index;
            end
            default: exp_index = idx;
        endcase
        @(posedge clk);
        #2;
        cmd_valid = 1'b0;
        if (op == tlb_pkg::TLB_OP_WRITE_INDEXED || op == tlb_pkg::TLB_OP_WRITE_RANDOM) begin
            model[exp_index] = entry;
        end
        last_index = exp_index;
        done = 1'b0;
        while (!done) begin
            @(negedge clk);
            check_flag("rsp_valid_o", rsp_valid, 1'b1);
            check_flag("cmd_ready_o", cmd_ready, 1'b0);
            check_index("rsp_index_o", rsp_index, exp_index);
            check_entry("rsp_entry_o", rsp_entry, exp_entry);
            check_flag("rsp_miss_o", rsp_miss, exp_miss);
            if (rsp_ready) begin
                done = 1'b1;
            end else begin
                @(posedge clk);
                #2;
                rsp_ready = stall_mode ? (rand_bits(2) == 0) : 1'b1;
            end
        end
    endtask

    always @(posedge clk) begin
        if (rst) begin
            edge_cnt <= 0;
        end else begin
            edge_cnt <= edge_cnt + 1;
        end
    end

    // accepted commands and delivered responses must pair up one to one
    always @(negedge clk) begin
        if (!rst && cmd_valid && cmd_ready) acc_seen++;
        if (!rst && rsp_valid && rsp_ready) rsp_seen++;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > CYCLE_LIMIT) begin
            $display("Timeout: no end of test after %0d cycles", CYCLE_LIMIT);
            $display("Simulation FAILED");
            $fatal(1, "cycle limit reached");
        end
    end

    initial begin
        tlb_pkg::tlb_entry_t e;
        tlb_pkg::tlb_index_t ix;
        lfsr       = 16'd17025;
        rst        = 1'b1;
        asid       = '0;
        inst_vaddr = '0;
        data_vaddr = '0;
        cmd_valid  = 1'b0;
        cmd_op     = tlb_pkg::TLB_OP_READ;
        cmd_index  = '0;
        cmd_entry  = '0;
        rsp_ready  = 1'b0;
        stall_mode = 1'b0;
        last_index = '0;
        cycles     = 0;
        acc_seen   = 0;
        rsp_seen   = 0;
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            model[i] = '0;
        end
        repeat (3) @(posedge clk);
        #2;
        rst = 1'b0;

        repeat (8) translate_random();  // empty array misses everywhere
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            issue(tlb_pkg::TLB_OP_READ, tlb_pkg::tlb_index_t'(i), '0);
        end

        repeat (40) issue(tlb_pkg::TLB_OP_WRITE_INDEXED, tlb_pkg::tlb_index_t'(rand_bits(4)),
                          rand_entry());
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            issue(tlb_pkg::TLB_OP_READ, tlb_pkg::tlb_index_t'(i), '0);
        end

        repeat (250) translate_random();

        // probe with all eight VPN2 values so misses show up too
        repeat (40) begin
            translate_random();
            e = rand_entry();
            e[`TLB_VPN2_HI:`TLB_VPN2_LO] = pool_vpn2(3'(rand_bits(3)));
            issue(tlb_pkg::TLB_OP_PROBE, '0, e);
        end

        repeat (30) begin
            repeat (rand_bits(2)) @(posedge clk);
            issue(tlb_pkg::TLB_OP_WRITE_RANDOM, tlb_pkg::tlb_index_t'(rand_bits(4)),
                  rand_entry());
            ix = last_index;
            issue(tlb_pkg::TLB_OP_READ, ix, '0);
        end

        stall_mode = 1'b1;
        repeat (120) begin
            issue(tlb_pkg::tlb_op_e'(rand_bits(2)), tlb_pkg::tlb_index_t'(rand_bits(4)),
                  rand_entry());
            translate_random();
        end

        repeat (2) @(posedge clk);
        @(negedge clk);
        if (rsp_seen != acc_seen) begin
            abort_run($sformatf("command count mismatch: %0d accepted, %0d answered",
                                acc_seen, rsp_seen));
        end else begin
            $display("Simulation PASSED");
            $finish;
        end
    end

endmodule

//--- tb/mmu_props.sv
module mmu_props (
    input logic                clk,
    input logic                rst,
    input logic                cmd_valid_i,
    input logic                cmd_ready_i,
    input tlb_pkg::tlb_op_e    cmd_op_i,
    input tlb_pkg::tlb_index_t cmd_index_i,
    input tlb_pkg::tlb_entry_t cmd_entry_i,
    input logic                rsp_valid_i,
    input logic                rsp_ready_i,
    input tlb_pkg::tlb_index_t rsp_index_i,
    input tlb_pkg::tlb_entry_t rsp_entry_i,
    input logic                rsp_miss_i
);
    timeunit 1ns;
    timeprecision 100ps;

    a_cmd_stable: assert property (@(posedge clk) disable iff (rst)
        cmd_valid_i && !cmd_ready_i |=> cmd_valid_i && $stable(cmd_op_i) &&
            $stable(cmd_index_i) && $stable(cmd_entry_i))
        else $error("command changed while waiting for ready");

    // a stalled response must keep all of its payload
    a_rsp_stable: assert property (@(posedge clk) disable iff (rst)
        rsp_valid_i && !rsp_ready_i |=> rsp_valid_i && $stable(rsp_index_i) &&
            $stable(rsp_entry_i) && $stable(rsp_miss_i))
        else $error("response changed while waiting for ready");

    // an accepted command keeps the unit busy until its response is taken
    a_one_in_flight: assert property (@(posedge clk) disable iff (rst)
        cmd_valid_i && cmd_ready_i |=> rsp_valid_i && !cmd_ready_i)
        else $error("accepted command did not block further commands");

    a_reset_idle: assert property (@(posedge clk) rst |=> !rsp_valid_i)
        else $error("response valid right after reset");

endmodule

bind tlb_op_unit mmu_props i_props (
    .clk         (clk),
    .rst         (rst),
    .cmd_valid_i (cmd_valid_i),
    .cmd_ready_i (cmd_ready_o),
    .cmd_op_i    (cmd_op_i),
    .cmd_index_i (cmd_index_i),
    .cmd_entry_i (cmd_entry_i),
    .rsp_valid_i (rsp_valid_o),
    .rsp_ready_i (rsp_ready_i),
    .rsp_index_i (rsp_index_o),
    .rsp_entry_i (rsp_entry_o),
    .rsp_miss_i  (rsp_miss_o)
);

//--- tb/tb_clock.sv
module tb_clock (
    output logic clk_o
);
    timeunit 1ns;
    timeprecision 100ps;

    // 20 ns period
    initial begin
        clk_o = 1'b0;
        forever #10 clk_o = ~clk_o;
    end

endmodule

//--- src/mmu_top.sv
module mmu_top (
    input  logic                clk,
    input  logic                rst,
    input  logic [7:0]          asid_i,

    input  tlb_pkg::vaddr_t     inst_vaddr_i,
    output tlb_pkg::paddr_t     inst_paddr_o,
    output logic                inst_miss_o,
    output logic                inst_valid_o,
    output logic                inst_uncached_o,

    input  tlb_pkg::vaddr_t     data_vaddr_i,
    output tlb_pkg::paddr_t     data_paddr_o,
    output logic                data_miss_o,
    output logic                data_valid_o,
    output logic                data_dirty_o,
    output logic                data_uncached_o,

    input  logic                cmd_valid_i,
    output logic                cmd_ready_o,
    input  tlb_pkg::tlb_op_e    cmd_op_i,
    input  tlb_pkg::tlb_index_t cmd_index_i,
    input  tlb_pkg::tlb_entry_t cmd_entry_i,

    output logic                rsp_valid_o,
    input  logic                rsp_ready_i,
    output tlb_pkg::tlb_index_t rsp_index_o,
    output tlb_pkg::tlb_entry_t rsp_entry_o,
    output logic                rsp_miss_o
);

    logic                tlb_we;
    tlb_pkg::tlb_index_t tlb_write_index;
    tlb_pkg::tlb_entry_t tlb_write_entry;
    tlb_pkg::tlb_index_t tlb_read_index;
    tlb_pkg::tlb_entry_t tlb_read_entry;
    logic [18:0]         tlb_probe_vpn2;
    logic                tlb_probe_miss;
    tlb_pkg::tlb_index_t tlb_probe_index;

    tlb_op_unit i_op_unit (
        .clk               (clk),
        .rst               (rst),
        .cmd_valid_i       (cmd_valid_i),
        .cmd_ready_o       (cmd_ready_o),
        .cmd_op_i          (cmd_op_i),
        .cmd_index_i       (cmd_index_i),
        .cmd_entry_i       (cmd_entry_i),
        .rsp_valid_o       (rsp_valid_o),
        .rsp_ready_i       (rsp_ready_i),
        .rsp_index_o       (rsp_index_o),
        .rsp_entry_o       (rsp_entry_o),
        .rsp_miss_o        (rsp_miss_o),
        .tlb_we_o          (tlb_we),
        .tlb_write_index_o (tlb_write_index),
        .tlb_write_entry_o (tlb_write_entry),
        .tlb_read_index_o  (tlb_read_index),
        .tlb_read_entry_i  (tlb_read_entry),
        .tlb_probe_vpn2_o  (tlb_probe_vpn2),
        .tlb_probe_miss_i  (tlb_probe_miss),
        .tlb_probe_index_i (tlb_probe_index)
    );

    tlb i_tlb (
        .clk             (clk),
        .rst             (rst),
        .asid_i          (asid_i),
        .inst_vaddr_i    (inst_vaddr_i),
        .inst_paddr_o    (inst_paddr_o),
        .inst_miss_o     (inst_miss_o),
        .inst_valid_o    (inst_valid_o),
        .inst_uncached_o (inst_uncached_o),
        .data_vaddr_i    (data_vaddr_i),
        .data_paddr_o    (data_paddr_o),
        .data_miss_o     (data_miss_o),
        .data_valid_o    (data_valid_o),
        .data_dirty_o    (data_dirty_o),
        .data_uncached_o (data_uncached_o),
        .we_i            (tlb_we),
        .write_index_i   (tlb_write_index),
        .write_entry_i   (tlb_write_entry),
        .read_index_i    (tlb_read_index),
        .read_entry_o    (tlb_read_entry),
        .probe_vpn2_i    (tlb_probe_vpn2),
        .probe_miss_o    (tlb_probe_miss),
        .probe_index_o   (tlb_probe_index)
    );

endmodule

//--- src/tlb_op_unit.sv
`include "tlb_defs.svh"

module tlb_op_unit (
    input  logic                clk,
    input  logic                rst,

    input  logic                cmd_valid_i,
    output logic                cmd_ready_o,
    input  tlb_pkg::tlb_op_e    cmd_op_i,
    input  tlb_pkg::tlb_index_t cmd_index_i,
    input  tlb_pkg::tlb_entry_t cmd_entry_i,

    output logic                rsp_valid_o,
    input  logic                rsp_ready_i,
    output tlb_pkg::tlb_index_t rsp_index_o,
    output tlb_pkg::tlb_entry_t rsp_entry_o,
    output logic                rsp_miss_o,

    output logic                tlb_we_o,
    output tlb_pkg::tlb_index_t tlb_write_index_o,
    output tlb_pkg::tlb_entry_t tlb_write_entry_o,
    output tlb_pkg::tlb_index_t tlb_read_index_o,
    input  tlb_pkg::tlb_entry_t tlb_read_entry_i,
    output logic [`TLB_VPN2_HI-`TLB_VPN2_LO:0] tlb_probe_vpn2_o,
    input  logic                tlb_probe_miss_i,
    input  tlb_pkg::tlb_index_t tlb_probe_index_i
);

    tlb_pkg::op_state_e  state_q;
    tlb_pkg::op_state_e  state_d;
    tlb_pkg::tlb_index_t random_q;
    logic                accept;
    logic                is_write;
    tlb_pkg::tlb_index_t rsp_index_d;

    assign cmd_ready_o = (state_q == tlb_pkg::ST_IDLE);
    assign rsp_valid_o = (state_q == tlb_pkg::ST_RESP);
    assign accept      = cmd_valid_i & cmd_ready_o;

    assign is_write = (cmd_op_i == tlb_pkg::TLB_OP_WRITE_INDEXED) ||
                      (cmd_op_i == tlb_pkg::TLB_OP_WRITE_RANDOM);

    // the write lands on the same edge that accepts the command
    assign tlb_we_o          = accept & is_write;
    assign tlb_write_index_o = (cmd_op_i == tlb_pkg::TLB_OP_WRITE_RANDOM) ? random_q
                                                                          : cmd_index_i;
    assign tlb_write_entry_o = cmd_entry_i;
    assign tlb_read_index_o  = cmd_index_i;
    assign tlb_probe_vpn2_o  = cmd_entry_i[`TLB_VPN2_HI:`TLB_VPN2_LO];

    always_comb begin
        case (cmd_op_i)
            tlb_pkg::TLB_OP_WRITE_RANDOM: rsp_index_d = random_q;
            tlb_pkg::TLB_OP_PROBE:        rsp_index_d = tlb_probe_index_i;  // zero on miss
            default:                      rsp_index_d = cmd_index_i;
        endcase
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            tlb_pkg::ST_IDLE: if (accept) state_d = tlb_pkg::ST_RESP;
            tlb_pkg::ST_RESP: if (rsp_ready_i) state_d = tlb_pkg::ST_IDLE;
            default:          state_d = tlb_pkg::ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q  <= tlb_pkg::ST_IDLE;
            random_q <= tlb_pkg::tlb_index_t'(`TLB_ENTRIES - 1);
        end else begin
            state_q  <= state_d;
            random_q <= random_q - 1'b1;  // free running, wraps around
        end
    end

    // response payload is only loaded in the accept cycle and held after that
    always_ff @(posedge clk) begin
        if (accept) begin
            rsp_index_o <= rsp_index_d;
            rsp_entry_o <= (cmd_op_i == tlb_pkg::TLB_OP_READ) ? tlb_read_entry_i : '0;
            rsp_miss_o  <= (cmd_op_i == tlb_pkg::TLB_OP_PROBE) & tlb_probe_miss_i;
        end
    end

endmodule

//--- src/tlb.sv
`include "tlb_defs.svh"

module tlb (
    input  logic                clk,
    input  logic                rst,
    input  logic [7:0]          asid_i,

    input  tlb_pkg::vaddr_t     inst_vaddr_i,
    output tlb_pkg::paddr_t     inst_paddr_o,
    output logic                inst_miss_o,
    output logic                inst_valid_o,
    output logic                inst_uncached_o,

    input  tlb_pkg::vaddr_t     data_vaddr_i,
    output tlb_pkg::paddr_t     data_paddr_o,
    output logic                data_miss_o,
    output logic                data_valid_o,
    output logic                data_dirty_o,
    output logic                data_uncached_o,

    input  logic                we_i,
    input  tlb_pkg::tlb_index_t write_index_i,
    input  tlb_pkg::tlb_entry_t write_entry_i,

    input  tlb_pkg::tlb_index_t read_index_i,
    output tlb_pkg::tlb_entry_t read_entry_o,

    input  logic [`TLB_VPN2_HI-`TLB_VPN2_LO:0] probe_vpn2_i,
    output logic                probe_miss_o,
    output tlb_pkg::tlb_index_t probe_index_o
);

    tlb_pkg::tlb_entry_t entries [0:`TLB_ENTRIES-1];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `TLB_ENTRIES; i++) begin
                entries[i] <= '0;
            end
        end else if (we_i) begin
            entries[write_index_i] <= write_entry_i;
        end
    end

    assign read_entry_o = entries[read_index_i];

    tlb_lookup i_lookup_inst (
        .entries_i     (entries),
        .vaddr_i       (inst_vaddr_i),
        .asid_i        (asid_i),
        .paddr_o       (inst_paddr_o),
        .miss_o        (inst_miss_o),
        .valid_o       (inst_valid_o),
        .dirty_o       (),
        .uncached_o    (inst_uncached_o),
        .match_index_o ()
    );

    tlb_lookup i_lookup_data (
        .entries_i     (entries),
        .vaddr_i       (data_vaddr_i),
        .asid_i        (asid_i),
        .paddr_o       (data_paddr_o),
        .miss_o        (data_miss_o),
        .valid_o       (data_valid_o),
        .dirty_o       (data_dirty_o),
        .uncached_o    (data_uncached_o),
        .match_index_o ()
    );

    // probe only needs the match, the low address bits are don't care
    tlb_lookup i_lookup_probe (
        .entries_i     (entries),
        .vaddr_i       ({probe_vpn2_i, 13'b0}),
        .asid_i        (asid_i),
        .paddr_o       (),
        .miss_o        (probe_miss_o),
        .valid_o       (),
        .dirty_o       (),
        .uncached_o    (),
        .match_index_o (probe_index_o)
    );

endmodule

//--- src/tlb_lookup.sv
`include "tlb_defs.svh"

module tlb_lookup (
    input  tlb_pkg::tlb_entry_t entries_i [0:`TLB_ENTRIES-1],
    input  tlb_pkg::vaddr_t     vaddr_i,
    input  logic [7:0]          asid_i,
    output tlb_pkg::paddr_t     paddr_o,
    output logic                miss_o,
    output logic                valid_o,
    output logic                dirty_o,
    output logic                uncached_o,
    output tlb_pkg::tlb_index_t match_index_o
);

    logic [`TLB_ENTRIES-1:0] match;
    logic                    hit;
    tlb_pkg::tlb_index_t     hit_index;
    tlb_pkg::tlb_entry_t     hit_entry;
    logic [`TLB_PAGE_W-1:0]  page;

    // all entries compared in parallel
    always_comb begin
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            match[i] = (entries_i[i][`TLB_VPN2_HI:`TLB_VPN2_LO] == vaddr_i[31:13]) &&
                       (entries_i[i][`TLB_G_BIT] ||
                        entries_i[i][`TLB_ASID_HI:`TLB_ASID_LO] == asid_i);
        end
    end

    // scanning downwards lets the lowest matching index win
    always_comb begin
        hit_index = '0;
        for (int i = `TLB_ENTRIES - 1; i >= 0; i--) begin
            if (match[i]) begin
                hit_index = tlb_pkg::tlb_index_t'(i);
            end
        end
    end

    assign hit       = |match;
    assign hit_entry = entries_i[hit_index];

    // bit 12 picks the odd page of the pair
    assign page = vaddr_i[12] ? hit_entry[`TLB_ODD_HI:`TLB_ODD_LO]
                              : hit_entry[`TLB_EVEN_HI:`TLB_EVEN_LO];

    assign miss_o        = ~hit;
    assign match_index_o = hit_index;  // already zero when nothing matches
    assign paddr_o       = hit ? {page[`TLB_PFN_HI:`TLB_PFN_LO], vaddr_i[11:0]} : '0;
    assign valid_o       = hit & page[`TLB_V_BIT];
    assign dirty_o       = hit & page[`TLB_D_BIT];
    assign uncached_o    = hit && (page[`TLB_C_HI:`TLB_C_LO] == 3'(`TLB_C_UNCACHED));

endmodule

//--- src/tlb_pkg.sv
`include "tlb_defs.svh"

package tlb_pkg;

    typedef logic [`TLB_ENTRY_W-1:0] tlb_entry_t;
    typedef logic [`TLB_WIDTH-1:0] tlb_index_t;

    typedef logic [31:0] vaddr_t;
    typedef logic [31:0] paddr_t;

    // maintenance commands, mirror TLBR/TLBWI/TLBWR/TLBP
    typedef enum logic [1:0] {
        TLB_OP_READ          = 2'd0,
        TLB_OP_WRITE_INDEXED = 2'd1,
        TLB_OP_WRITE_RANDOM  = 2'd2,
        TLB_OP_PROBE         = 2'd3
    } tlb_op_e;

    typedef enum logic {
        ST_IDLE = 1'b0,
        ST_RESP = 1'b1
    } op_state_e;

endpackage

//--- src/tlb_defs.svh
`ifndef TLB_DEFS_SVH
`define TLB_DEFS_SVH

`define TLB_ENTRIES     16
`define TLB_WIDTH       4
`define TLB_ENTRY_W     86

// entry layout, one even/odd page pair per entry
`define TLB_ASID_HI     85
`define TLB_ASID_LO     78
`define TLB_MASK_HI     77  // reserved, always zero
`define TLB_MASK_LO     71
`define TLB_VPN2_HI     70
`define TLB_VPN2_LO     52
`define TLB_G_BIT       51
`define TLB_EVEN_HI     50
`define TLB_EVEN_LO     26
`define TLB_ODD_HI      25
`define TLB_ODD_LO      1

// fields inside one 25-bit page descriptor
`define TLB_PAGE_W      25
`define TLB_PFN_HI      24
`define TLB_PFN_LO      5
`define TLB_C_HI        4
`define TLB_C_LO        2
`define TLB_D_BIT       1
`define TLB_V_BIT       0

`define TLB_C_UNCACHED  2

`endif
